//--- project.f
+incdir+src
src/cpuPkg.sv
src/memArray.sv
src/regFile.sv
src/alu.sv
src/decoder.sv
src/cpu.sv
sim/tbClock.sv
sim/cpuTb.sv

//--- run.sh
#!/bin/sh
# Builds the processor and its testbench with Verilator, runs it
# and grades the run from the simulation log
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module cpuTb -o cpuSim

./obj_dir/cpuSim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
	echo "Simulation ended without a result line, see $LOG"
	exit 1
fi
echo "Simulation passed"

//--- sim/cpuTb.sv
////////////////////////////////////////////////////////////
// Testbench for the pipelined processor
// Builds programs, loads them in reset, runs a model of the
// ISA and checks every retired write, halt timing and pc
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_params.svh"

module cpuTb import cpuPkg::*; ();

	logic clk, arstN, hold, hlt;
	progWriteT progWrite;
	logic [`IMEM_AW-1:0] pc;
	wbTraceT wbTrace;

	// Program under test and model results
	instrT   prog [$];
	wbTraceT expQ [$];
	int      lastWr [`REG_CNT];
	int      hltIdx;
	int      seed = 32'h34ba;
	int      budget = 0;
	int      testNum = 0;
	int      failedTests = 0;
	string   curName;
	logic    running = 1'b0;

	// Checker state
	int errorCount = 0;
	int doneCount = 0;
	int cyc, trIdx, haltCyc, watchCycles;
	bit finished;

	tbClock clkGen (.hold(hold), .clk(clk), .arstN(arstN));

	cpu cpu_inst (
		.clk      (clk),
		.arstN    (arstN),
		.progWrite(progWrite),
		.hlt      (hlt),
		.pc       (pc),
		.wbTrace  (wbTrace)
	);

	////////////////////////////////////////////////////////////
	// Program building
	////////////////////////////////////////////////////////////

	// Two slots between a write and its first reader
	function automatic bit settled(input int r);
		return r == 0 || prog.size() - lastWr[r] >= 3;
	endfunction

	function automatic bit sourcesReady(input instrT ins);
		bit rsUse, rtUse, rdUse;
		rsUse = ins.opcode inside {opAdd, opSub, opXor, opSll, opSra, opRor, opLw, opSw};
		rtUse = ins.opcode inside {opAdd, opSub, opXor};
		rdUse = ins.opcode inside {opSw, opLlb, opLhb};
		return (!rsUse || settled(int'(ins.rs))) && (!rtUse || settled(int'(ins.rt)))
			&& (!rdUse || settled(int'(ins.rd)));
	endfunction

	function automatic void newProgram();
		prog.delete();
		foreach (lastWr[i]) lastWr[i] = -8;
	endfunction

	// Appends one word after ADD r0 fillers for any unsettled source
	function automatic void emit(input opcodeT op, input int rd, input int rs, input int rt);
		instrT ins, filler;
		filler = '0;
		filler.opcode = opAdd;
		ins.opcode = op;
		ins.rd = regIdxT'(rd);
		ins.rs = regIdxT'(rs);
		ins.rt = regIdxT'(rt);
		while (!sourcesReady(ins)) prog.push_back(filler);
		prog.push_back(ins);
		if (!(op inside {opSw, opHlt})) lastWr[rd] = prog.size() - 1;
	endfunction

	function automatic void loadWord(input int rd, input dataT value);
		emit(opLlb, rd, int'(value[7:4]), int'(value[3:0]));
		emit(opLhb, rd, int'(value[15:12]), int'(value[11:8]));
	endfunction

	// Random register that is already safe to read
	function automatic int pickSource();
		int r;
		repeat (6) begin
			r = {$random(seed)} % `REG_CNT;
			if (settled(r)) return r;
		end
		return 0;
	endfunction

	function automatic void buildArith();
		newProgram();
		loadWord(1, 16'hFFF0);
		loadWord(2, 16'h0025);
		loadWord(3, 16'h8001);
		loadWord(4, 16'h7FFF);
		// Carry out of bit 15 is lost
		emit(opAdd, 5, 1, 2);
		emit(opAdd, 6, 3, 3);
		emit(opAdd, 7, 4, 4);
		emit(opSub, 8, 2, 1);
		emit(opSub, 9, 0, 2);
		emit(opXor, 10, 1, 3);
		emit(opXor, 11, 5, 8);
		emit(opHlt, 0, 0, 0);
	endfunction

	function automatic void buildShifts();
		newProgram();
		loadWord(1, 16'h8D35);
		loadWord(2, 16'h4B1E);
		for (int s = 0; s < 16; s++) begin
			emit(opSll, 3, 1, s);
			emit(opSra, 4, 1, s);
			emit(opRor, 5, 1, s);
			emit(opSra, 6, 2, s);
		end
		emit(opHlt, 0, 0, 0);
	endfunction

	function automatic void buildByteLoads();
		newProgram();
		loadWord(1, 16'hA5C3);
		emit(opLlb, 1, 'h7, 'hE);
		emit(opLhb, 1, 'h1, 'h9);
		// r0 writes retire but leave r0 at zero
		emit(opLlb, 0, 'h5, 'h5);
		emit(opLhb, 0, 'hA, 'hA);
		emit(opAdd, 2, 0, 1);
		emit(opXor, 3, 1, 0);
		emit(opLhb, 4, 'hC, 'h3);
		emit(opHlt, 0, 0, 0);
	endfunction

	function automatic void buildMemory();
		newProgram();
		loadWord(1, 16'h0040);
		loadWord(2, 16'hBEEF);
		loadWord(3, 16'h1234);
		// Offsets +6 and -8 bytes
		emit(opSw, 2, 1, 'h3);
		emit(opSw, 3, 1, 'hC);
		emit(opLw, 4, 1, 'h3);
		emit(opLw, 5, 1, 'hC);
		// Never written since reset
		emit(opLw, 6, 1, 'h7);
		emit(opLw, 7, 0, 'hF);
		emit(opHlt, 0, 0, 0);
	endfunction

	function automatic void buildHalt();
		newProgram();
		loadWord(1, 16'h1357);
		emit(opAdd, 2, 1, 1);
		emit(opHlt, 0, 0, 0);
		// Must never run
		emit(opAdd, 3, 1, 1);
		emit(opLlb, 4, 'hF, 'hF);
		emit(opSw, 1, 0, 0);
	endfunction

	function automatic void buildRandom();
		opcodeT ops [10] = '{opAdd, opSub, opXor, opSll, opSra, opRor,
			opLw, opSw, opLlb, opLhb};
		opcodeT op;
		int rd;
		newProgram();
		for (int n = 0; n < 200; n++) begin
			op = ops[{$random(seed)} % 10];
			if (op inside {opSw, opLlb, opLhb}) rd = pickSource();
			else rd = {$random(seed)} % `REG_CNT;
			if (op inside {opAdd, opSub, opXor}) begin
				emit(op, rd, pickSource(), pickSource());
			end else if (op inside {opLlb, opLhb}) begin
				emit(op, rd, {$random(seed)} % 16, {$random(seed)} % 16);
			end else begin
				emit(op, rd, pickSource(), {$random(seed)} % 16);
			end
		end
		emit(opHlt, 0, 0, 0);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Runs prog in order, fills expQ, returns the HLT address
	function automatic int runModel();
		dataT regs [`REG_CNT];
		dataT dmem [2**`DMEM_AW];
		dataT a, b, d, val, addr;
		logic [7:0] imm8;
		logic [`DMEM_AW-1:0] wordIdx;
		int ofs;
		logic wr;
		instrT ins;
		wbTraceT trace;
		foreach (regs[i]) regs[i] = '0;
		foreach (dmem[i]) dmem[i] = '0;
		expQ.delete();
		for (int i = 0; i < prog.size(); i++) begin
			ins = prog[i];
			a = regs[ins.rs];
			b = regs[ins.rt];
			d = regs[ins.rd];
			imm8 = {ins.rs, ins.rt};
			// Offset in halfwords, then byte address to word index
			ofs = ins.rt[3] ? int'(ins.rt) - 16 : int'(ins.rt);
			addr = a + dataT'(ofs * 2);
			wordIdx = `DMEM_AW'(addr >> 1);
			wr = 1'b1;
			case (ins.opcode)
				opAdd: val = a + b;
				opSub: val = a - b;
				opXor: val = a ^ b;
				opSll: val = a << ins.rt;
				opSra: val = dataT'($signed(a) >>> ins.rt);
				opRor: val = (a >> ins.rt) | (a << (16 - int'(ins.rt)));
				opLw:  val = dmem[wordIdx];
				opSw: begin
					dmem[wordIdx] = d;
					wr = 1'b0;
				end
				opLlb: val = {d[15:8], imm8};
				opLhb: val = {imm8, d[7:0]};
				opHlt: return i;
				default: wr = 1'b0;
			endcase
			if (wr) begin
				trace = '{valid: 1'b1, rd: ins.rd, data: val};
				expQ.push_back(trace);
				if (ins.rd != '0) regs[ins.rd] = val;
			end
		end
		return prog.size();
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkTrace(input wbTraceT exp, input wbTraceT act);
		if (act !== exp) begin
			$display("error: wbTrace write %0d expected %h got %h", trIdx, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkPc(input logic [`IMEM_AW-1:0] exp, input logic [`IMEM_AW-1:0] act);
		if (act !== exp) begin
			$display("error: pc expected %h got %h", exp, act);
			errorCount++;
		end
	endtask

	task automatic checkCount(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("error: %s expected %h got %h", what, exp, act);
			errorCount++;
		end
	endtask

	// Sampled mid-cycle with cycle 1 just after the first edge out of reset
	always @(negedge clk) begin
		if (!running) begin
			cyc = 0;
			trIdx = 0;
			haltCyc = -1;
			finished = 1'b0;
		end else if (!finished) begin
			cyc++;
			if (wbTrace.valid) begin
				if (trIdx < expQ.size()) begin
					checkTrace(expQ[trIdx], wbTrace);
				end else begin
					$display("Unexpected write to r%0d retired in cycle %0d", wbTrace.rd, cyc);
					errorCount++;
				end
				trIdx++;
			end
			if (haltCyc < 0) begin
				if (hlt) begin
					haltCyc = cyc;
					checkPc(`IMEM_AW'(hltIdx), pc);
					checkCount("cycles to halt", hltIdx + 4, cyc);
					checkCount("retired writes", expQ.size(), trIdx);
				end
			end else begin
				if (!hlt) begin
					$display("Halt output dropped in cycle %0d", cyc);
					errorCount++;
				end
				// A few idle cycles to catch late writes
				if (cyc == haltCyc + 6) begin
					checkPc(`IMEM_AW'(hltIdx), pc);
					finished = 1'b1;
					doneCount++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic loadProgram();
		@(posedge clk);
		#1;
		hold = 1'b1;
		foreach (prog[i]) begin
			progWrite.we = 1'b1;
			progWrite.addr = `IMEM_AW'(i);
			progWrite.instr = prog[i];
			@(posedge clk);
			#1;
		end
		progWrite = '0;
		repeat (8) @(posedge clk);
		#1;
		hold = 1'b0;
		wait (arstN === 1'b1);
		@(posedge clk);
		#1;
	endtask

	task automatic runTest(input string name);
		int errBefore;
		errBefore = errorCount;
		curName = name;
		hltIdx = runModel();
		budget += 20 * prog.size();
		running = 1'b0;
		loadProgram();
		testNum++;
		running = 1'b1;
		wait (doneCount == testNum);
		running = 1'b0;
		if (errorCount == errBefore) begin
			$display("Test %s: passed, %0d writes checked", name, expQ.size());
		end else begin
			$display("Test %s: failed with %0d errors", name, errorCount - errBefore);
			failedTests++;
		end
	endtask

	initial begin
		progWrite = '0;
		hold = 1'b1;
		running = 1'b0;
		buildArith();
		runTest("arithmetic");
		buildShifts();
		runTest("shifts");
		buildByteLoads();
		runTest("byte loads");
		buildMemory();
		runTest("memory");
		buildHalt();
		runTest("halt");
		buildRandom();
		runTest("random");
		$display("Summary: %0d tests, %0d failed, %0d errors", testNum, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Budget grows by 20 cycles per word as each test starts
	initial begin
		watchCycles = 0;
		while (watchCycles <= budget) begin
			@(posedge clk);
			watchCycles++;
		end
		$display("Timeout in test %s after %0d cycles without a halt", curName, watchCycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- sim/tbClock.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 4 ns clock; reset is low for the first 8 cycles and
// whenever the testbench raises hold
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbClock #(
	parameter int halfPeriod  = 2,
	parameter int resetCycles = 8
) (
	input  logic hold,
	output logic clk,
	output logic arstN
);

	logic porDone;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Power-on reset, released just after a rising edge
	initial begin
		porDone = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1;
		porDone = 1'b1;
	end

	assign arstN = porDone && !hold;

endmodule

//--- src/cpu.sv
////////////////////////////////////////////////////////////
// Five-stage pipelined 16-bit processor, top level
// No forwarding and no stalls; software spaces dependent
// instructions. Program loads through progWrite in reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu import cpuPkg::*; (
	input  logic                clk,
	input  logic                arstN,
	input  progWriteT           progWrite,
	output logic                hlt,
	output logic [`IMEM_AW-1:0] pc,
	output wbTraceT             wbTrace
);

	// Fetch
	instrT               fetchInstr;
	logic [`IMEM_AW-1:0] imemAddr;

	// Decode
	instrT  ifIdInstr;
	logic   ifIdValid;
	ctrlT   rawCtrl;
	ctrlT   idCtrl;
	regIdxT rdAddrB;
	dataT   regDataA;
	dataT   regDataB;
	dataT   idImm;

	// Execute, memory, writeback
	idExT  idEx;
	dataT  aluA;
	dataT  aluB;
	dataT  aluResult;
	exMemT exMem;
	dataT  dmemRdata;
	memWbT memWb;
	dataT  wbData;
	logic  haltSeen;

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////

	// Load port owns the address during program load
	assign imemAddr = progWrite.we ? progWrite.addr : pc;

	memArray #(
		.wordT       (instrT),
		.AW          (`IMEM_AW),
		.clearOnReset(1'b0)
	) instMem (
		.clk  (clk),
		.arstN(arstN),
		.we   (progWrite.we),
		.addr (imemAddr),
		.wdata(progWrite.instr),
		.rdata(fetchInstr)
	);

	// PC parks on the HLT word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (fetchInstr.opcode != opHlt) begin
			pc <= pc + 1'b1;
		end
	end

	// IF/ID, valid bit keeps the reset word from decoding as ADD
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ifIdValid <= 1'b0;
			ifIdInstr <= '0;
		end else begin
			ifIdValid <= 1'b1;
			ifIdInstr <= fetchInstr;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	decoder dec (
		.instr(ifIdInstr),
		.ctrl (rawCtrl)
	);

	assign idCtrl = ifIdValid ? rawCtrl : '0;

	// SW and the byte loads read rd on port B
	assign rdAddrB = (rawCtrl.memWrite || rawCtrl.byteLoad) ? ifIdInstr.rd : ifIdInstr.rt;

	regFile regs (
		.clk    (clk),
		.arstN  (arstN),
		.rdAddrA(ifIdInstr.rs),
		.rdAddrB(rdAddrB),
		.wrEn   (memWb.ctrl.regWrite),
		.wrAddr (memWb.rd),
		.wrData (wbData),
		.rdDataA(regDataA),
		.rdDataB(regDataB)
	);

	// Immediate forms
	always_comb begin
		if (rawCtrl.byteLoad) begin
			// 8-bit value from rs and imm fields
			idImm = {{(`DATA_W-8){1'b0}}, ifIdInstr.rs, ifIdInstr.rt};
		end else if (rawCtrl.memRead || rawCtrl.memWrite) begin
			// Sign-extended offset, byte units
			idImm = {{(`DATA_W-5){ifIdInstr.rt[3]}}, ifIdInstr.rt, 1'b0};
		end else begin
			idImm = {{(`DATA_W-4){1'b0}}, ifIdInstr.rt};
		end
	end

	// ID/EX
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else begin
			idEx.ctrl <= idCtrl;
			idEx.regA <= regDataA;
			idEx.regB <= regDataB;
			idEx.imm  <= idImm;
			idEx.rd   <= ifIdInstr.rd;
		end
	end

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////

	// Byte loads modify the old rd value
	assign aluA = idEx.ctrl.byteLoad ? idEx.regB : idEx.regA;
	assign aluB = idEx.ctrl.useImm ? idEx.imm : idEx.regB;

	alu aluInst (
		.aluSel  (idEx.ctrl.aluSel),
		.byteLoad(idEx.ctrl.byteLoad),
		.opA     (aluA),
		.opB     (aluB),
		.result  (aluResult)
	);

	// EX/MEM
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
		end else begin
			exMem.ctrl      <= idEx.ctrl;
			exMem.result    <= aluResult;
			exMem.storeData <= idEx.regB;
			exMem.rd        <= idEx.rd;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory
	////////////////////////////////////////////////////////////

	// Byte address to word index, bit 0 dropped
	memArray #(
		.wordT       (dataT),
		.AW          (`DMEM_AW),
		.clearOnReset(1'b1)
	) dataMem (
		.clk  (clk),
		.arstN(arstN),
		.we   (exMem.ctrl.memWrite),
		.addr (exMem.result[`DMEM_AW:1]),
		.wdata(exMem.storeData),
		.rdata(dmemRdata)
	);

	// MEM/WB
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memWb <= '0;
		end else begin
			memWb.ctrl    <= exMem.ctrl;
			memWb.result  <= exMem.result;
			memWb.memData <= exMem.ctrl.memRead ? dmemRdata : '0;
			memWb.rd      <= exMem.rd;
		end
	end

	////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////

	assign wbData = memWb.ctrl.memToReg ? memWb.memData : memWb.result;

	// Retire trace, r0 writes still show as valid
	assign wbTrace.valid = memWb.ctrl.regWrite;
	assign wbTrace.rd    = memWb.rd;
	assign wbTrace.data  = wbData;

	// Sticky halt once HLT retires
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			haltSeen <= 1'b0;
		end else if (memWb.ctrl.halt) begin
			haltSeen <= 1'b1;
		end
	end

	assign hlt = haltSeen | memWb.ctrl.halt;

endmodule

//--- src/decoder.sv
////////////////////////////////////////////////////////////
// Opcode to control bundle for the later stages
// Unused opcodes give a bubble
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decoder import cpuPkg::*; (
	input  instrT instr,
	output ctrlT  ctrl
);

	always_comb begin
		ctrl = '0;
		case (instr.opcode)
			opAdd, opSub, opXor: begin
				ctrl.aluSel   = instr.opcode;
				ctrl.regWrite = 1'b1;
			end
			// Shift amount from the rt field
			opSll, opSra, opRor: begin
				ctrl.aluSel   = instr.opcode;
				ctrl.useImm   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opLw: begin
				ctrl.aluSel   = opAdd;
				ctrl.useImm   = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			// Store data comes from rd on port B
			opSw: begin
				ctrl.aluSel   = opAdd;
				ctrl.useImm   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opLlb, opLhb: begin
				ctrl.aluSel   = instr.opcode;
				ctrl.useImm   = 1'b1;
				ctrl.byteLoad = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// No register or memory write on any copy
			opHlt: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

//--- src/alu.sv
////////////////////////////////////////////////////////////
// Execute stage unit
// Add, sub, xor, shifts, rotate and the byte loads
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_params.svh"

module alu import cpuPkg::*; (
	input  opcodeT aluSel,
	input  logic   byteLoad,
	input  dataT   opA,
	input  dataT   opB,
	output dataT   result
);

	logic [3:0]          shamt;
	logic [2*`DATA_W-1:0] rotWide;
	dataT                arith;

	// Shift amount is always the low nibble
	assign shamt = opB[3:0];

	// Doubled word so a right shift yields the rotation
	assign rotWide = {opA, opA} >> shamt;

	always_comb begin
		case (aluSel)
			opSub: arith = opA - opB;
			opXor: arith = opA ^ opB;
			opSll: arith = opA << shamt;
			opSra: arith = $signed(opA) >>> shamt;
			opRor: arith = rotWide[`DATA_W-1:0];
			// Add path, also address calc for LW/SW
			default: arith = opA + opB;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Byte loads
	////////////////////////////////////////////////////////////

	// opA holds the old rd, opB the 8-bit immediate
	always_comb begin
		if (!byteLoad) begin
			result = arith;
		end else if (aluSel == opLhb) begin
			result = {opB[7:0], opA[7:0]};
		end else begin
			// LLB keeps the upper byte
			result = {opA[`DATA_W-1:8], opB[7:0]};
		end
	end

endmodule

//--- src/regFile.sv
////////////////////////////////////////////////////////////
// Sixteen-entry register file, two read ports, one write
// Same-cycle writes pass through to the read ports
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_params.svh"

module regFile import cpuPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  regIdxT rdAddrA,
	input  regIdxT rdAddrB,
	input  logic   wrEn,
	input  regIdxT wrAddr,
	input  dataT   wrData,
	output dataT   rdDataA,
	output dataT   rdDataB
);

	dataT regs [`REG_CNT];
	logic wrLive;

	// r0 never takes a write
	assign wrLive = wrEn && (wrAddr != '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Read A, bypass the writeback value
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];

	// Read B, same rules
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

//--- src/memArray.sv
////////////////////////////////////////////////////////////
// Word memory, asynchronous read and clocked write
// Word type set per instance, optional clear on reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_params.svh"

module memArray #(
	parameter type wordT = logic [`DATA_W-1:0],
	parameter int AW = `DMEM_AW,
	parameter bit clearOnReset = 1'b1
) (
	input  logic          clk,
	input  logic          arstN,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  wordT          wdata,
	output wordT          rdata
);

	wordT mem [2**AW];

	// Combinational read port
	assign rdata = mem[addr];

	generate
		if (clearOnReset) begin : genClear
			always_ff @(posedge clk or negedge arstN) begin
				if (!arstN) begin
					mem <= '{default: '0};
				end else if (we) begin
					mem[addr] <= wdata;
				end
			end
		end else begin : genKeep
			// Contents kept across reset
			always_ff @(posedge clk) begin
				if (we) begin
					mem[addr] <= wdata;
				end
			end
		end
	endgenerate

endmodule

//--- src/cpuPkg.sv
////////////////////////////////////////////////////////////
// Shared types for the pipelined processor
// Opcodes, instruction layout, control bundle, stage
// registers, program load port and retire trace
////////////////////////////////////////////////////////////

`include "cpu_params.svh"

package cpuPkg;

	// Kept subset of the ISA at its standard encodings
	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opXor = 4'h2,
		opSll = 4'h4,
		opSra = 4'h5,
		opRor = 4'h6,
		opLw  = 4'h8,
		opSw  = 4'h9,
		opLlb = 4'hA,
		opLhb = 4'hB,
		opHlt = 4'hF
	} opcodeT;

	typedef logic [`DATA_W-1:0] dataT;
	typedef logic [$clog2(`REG_CNT)-1:0] regIdxT;

	// [opcode][rd][rs][rt/imm]
	typedef struct packed {
		opcodeT opcode;
		regIdxT rd;
		regIdxT rs;
		regIdxT rt;
	} instrT;

	// Control bundle with all bits low for a bubble
	typedef struct packed {
		opcodeT aluSel;
		logic   useImm;
		logic   memRead;
		logic   memWrite;
		logic   regWrite;
		logic   memToReg;
		logic   byteLoad;
		logic   halt;
	} ctrlT;

	////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////

	typedef struct packed {
		ctrlT   ctrl;
		dataT   regA;      // rs value
		dataT   regB;      // rt or rd value
		dataT   imm;
		regIdxT rd;
	} idExT;

	typedef struct packed {
		ctrlT   ctrl;
		dataT   result;
		dataT   storeData;
		regIdxT rd;
	} exMemT;

	typedef struct packed {
		ctrlT   ctrl;
		dataT   result;
		dataT   memData;
		regIdxT rd;
	} memWbT;

	// Instruction memory load port
	typedef struct packed {
		logic                we;
		logic [`IMEM_AW-1:0] addr;
		instrT               instr;
	} progWriteT;

	// One retiring register write
	typedef struct packed {
		logic   valid;
		regIdxT rd;
		dataT   data;
	} wbTraceT;

endpackage

//--- src/cpu_params.svh
////////////////////////////////////////////////////////////
// Sizing macros for the five-stage 16-bit processor
// Included by the package and by any module that sizes
// ports or arrays from these values
////////////////////////////////////////////////////////////

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path width, registers and memory words
`define DATA_W 16

// Size of the architectural register file
`define REG_CNT 16

// Word address widths
`define IMEM_AW 8
`define DMEM_AW 8

`endif
